//--- hdl/s16b_pkg.sv
package s16b_pkg;

    // One 68000 bus cycle, A0 is carried by the two data strobes
    typedef struct packed {
        logic [23:1] addr;
        logic        as_n;
        logic        rnw;
        logic        uds_n;
        logic        lds_n;
        logic [15:0] dout;   // CPU write data
    } cpu_bus_t;

    // Registered chip selects, at most one high per cycle
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic text;
        logic objram;
        logic pal;
        logic io;
        logic tbank;   // Tile bank port on 5521/5704 boards
    } chip_sel_t;

    typedef struct packed {
        logic [7:0] joystick1;
        logic [7:0] joystick2;
        logic [7:0] joystick3;
        logic [7:0] joystick4;
        logic [7:0] ana1;      // High bytes of the analog inputs
        logic [7:0] ana2;
        logic [7:0] ana3;
        logic [7:0] ana4;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic [2:0] spare;     // Held at 1
    } cab_in_t;

    typedef struct packed {
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
        logic       dip_test;
        logic       dip_pause;
    } dip_t;

    // Fixed map, region is A22..A20. Regions 0 to 2 hold the program ROM
    localparam logic [2:0] REG_RAM  = 3'd3;
    localparam logic [2:0] REG_ORAM = 3'd4;
    localparam logic [2:0] REG_VRAM = 3'd5;
    localparam logic [2:0] REG_PAL  = 3'd6;
    localparam logic [2:0] REG_IO   = 3'd7;

    localparam logic [7:0] GAME_HWCHAMP  = 8'h01;
    localparam logic [7:0] GAME_PASSSHT  = 8'h02;
    localparam logic [7:0] GAME_BULLET   = 8'h11;
    localparam logic [7:0] GAME_SDI      = 8'h12;
    localparam logic [7:0] GAME_PASSSHT2 = 8'h13;  // Passing Shot (J)
    localparam logic [7:0] GAME_PASSSHT3 = 8'h18;
    localparam logic [7:0] GAME_DEFENSE  = 8'h19;

    localparam logic [7:0] IDLE_BYTE = 8'hff;   // Undriven cabinet port

endpackage

//--- hdl/s16b_mem_decode.sv
`timescale 1ns/100ps

module s16b_mem_decode (
    input  logic                clk,
    input  logic                rst,
    input  s16b_pkg::cpu_bus_t  bus,
    input  logic [7:0]          game_id,
    output s16b_pkg::chip_sel_t sel,
    output logic [17:0]         rom_addr
);

    logic [2:0] region;
    logic       strobe;    // Either data strobe active
    logic [1:0] rom_enc;   // ROM bank from the region number
    logic       rom_reg;
    logic       large_5358;

    assign region     = bus.addr[22:20];
    assign strobe     = !bus.uds_n || !bus.lds_n;
    assign rom_reg    = region < s16b_pkg::REG_RAM;
    assign large_5358 = game_id == 8'h10 || game_id == 8'h1a;

    // Selects follow AS, one edge late
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (!bus.as_n) begin
            sel.rom    <= rom_reg && bus.rnw;
            sel.ram    <= strobe && region == s16b_pkg::REG_RAM;
            sel.vram   <= strobe && region == s16b_pkg::REG_VRAM && !bus.addr[16];
            sel.text   <= region == s16b_pkg::REG_VRAM && bus.addr[16];
            sel.objram <= region == s16b_pkg::REG_ORAM;
            sel.pal    <= region == s16b_pkg::REG_PAL;
            sel.io     <= region == s16b_pkg::REG_IO;
            sel.tbank  <= region == 3'd2 && !bus.rnw;   // Write only
        end else begin
            sel <= '0;
        end
    end

    always_comb begin
        case (region)
            3'd1:    rom_enc = 2'd1;
            3'd2:    rom_enc = 2'd2;
            default: rom_enc = 2'd0;
        endcase
    end

    // Program ROM layout depends on the board type
    always_comb begin
        casez (game_id[7:3])
            5'b001??: begin   // 5797
                rom_addr = bus.addr[18:1];
            end
            5'b0001?: begin   // 5358
                if (large_5358) begin
                    rom_addr = {rom_enc, bus.addr[16:1]};
                end else begin
                    rom_addr = {1'b0, rom_enc, bus.addr[15:1]};
                end
            end
            5'b00001: begin   // Korean boards
                rom_addr = {1'b0, bus.addr[17:1]};
            end
            default: begin    // 5521 and 5704
                rom_addr = {rom_enc[0], bus.addr[17:1]};
            end
        endcase
    end

endmodule

//--- hdl/s16b_cab_io.sv
`timescale 1ns/100ps

module s16b_cab_io (
    input  logic                clk,
    input  logic                rst,
    input  s16b_pkg::cpu_bus_t  bus,
    input  s16b_pkg::chip_sel_t sel,
    input  logic [7:0]          game_id,
    input  s16b_pkg::cab_in_t   cab,
    input  s16b_pkg::dip_t      dip,
    output logic [7:0]          cab_dout
);

    logic       last_io;     // I/O select on the previous edge
    logic [7:0] ana_shift;   // Heavy Champion analog port
    logic [8:0] ana_sum;
    logic       is_bullet;
    logic       is_passsht;
    logic       bus_wr;
    logic       grp3_on;
    logic [7:0] sys_byte;
    logic [7:0] sort1;
    logic [7:0] sort2;
    logic [7:0] sort3;

    // Board wiring of the joystick lines
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    function automatic logic [7:0] pass_joy(input logic [7:0] joy);
        pass_joy = {joy[7:4], joy[1:0], joy[3:2]};
    endfunction

    function automatic logic [7:0] swap_nib(input logic [7:0] b);
        swap_nib = {b[3:0], b[7:4]};
    endfunction

    assign is_bullet  = game_id == s16b_pkg::GAME_BULLET;
    assign is_passsht = game_id == s16b_pkg::GAME_PASSSHT ||
                        game_id == s16b_pkg::GAME_PASSSHT2 ||
                        game_id == s16b_pkg::GAME_PASSSHT3;
    assign bus_wr     = !bus.rnw && (!bus.lds_n || !bus.uds_n);
    assign grp3_on    = bus.addr[9:8] == 2'b10;

    // Sign extended so the halved sum stays in range
    assign ana_sum = {cab.ana1[7], cab.ana1} + {cab.ana2[7], cab.ana2};

    assign sort1 = sort_joy(cab.joystick1);
    assign sort2 = sort_joy(cab.joystick2);
    assign sort3 = sort_joy(cab.joystick3);

    always_comb begin
        sys_byte = {2'b11, cab.start[1:0], cab.service, dip.dip_test, cab.coin[1:0]};
        if (is_bullet) begin
            sys_byte[7:6] = {cab.coin[2], cab.start[2]};
        end else if (is_passsht) begin
            sys_byte[7:6] = cab.start[3:2];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout  <= s16b_pkg::IDLE_BYTE;
            last_io   <= 1'b0;
            ana_shift <= s16b_pkg::IDLE_BYTE;
        end else begin
            last_io  <= sel.io;
            cab_dout <= s16b_pkg::IDLE_BYTE;
            if (sel.io) begin
                case (bus.addr[13:12])
                    2'd1: begin
                        case (bus.addr[2:1])
                            2'd0: cab_dout <= sys_byte;
                            2'd1: cab_dout <= is_bullet ? swap_nib(sort1) : sort1;
                            2'd2: begin
                                if (is_bullet) cab_dout <= swap_nib(sort3);
                            end
                            default: cab_dout <= is_bullet ? swap_nib(sort2) : sort2;
                        endcase
                    end
                    2'd2: cab_dout <= bus.addr[1] ? dip.dipsw_a : dip.dipsw_b;
                    2'd3: begin
                        if (grp3_on) begin
                            case (game_id)
                                s16b_pkg::GAME_HWCHAMP: begin
                                    if (bus_wr) begin
                                        case (bus.addr[2:1])
                                            2'd0: ana_shift <= ana_sum[8:1];
                                            2'd1: ana_shift <= cab.ana1;
                                            2'd2: ana_shift <= cab.ana2;
                                            default: ana_shift <= 8'hff;
                                        endcase
                                    end else if (!last_io) begin
                                        // One bit per read, MSB first
                                        ana_shift <= ana_shift << 1;
                                        cab_dout  <= {7'd0, ana_shift[7]};
                                    end else begin
                                        cab_dout <= cab_dout;   // Hold until cycle ends
                                    end
                                end
                                s16b_pkg::GAME_PASSSHT2: begin
                                    case (bus.addr[2:1])
                                        2'd0: cab_dout <= pass_joy(cab.joystick1);
                                        2'd1: cab_dout <= pass_joy(cab.joystick2);
                                        2'd2: cab_dout <= pass_joy(cab.joystick3);
                                        default: cab_dout <= pass_joy(cab.joystick4);
                                    endcase
                                end
                                s16b_pkg::GAME_SDI, s16b_pkg::GAME_DEFENSE: begin
                                    case (bus.addr[2:1])
                                        2'd0: cab_dout <= cab.ana1;   // 1P
                                        2'd1: cab_dout <= cab.ana2;
                                        2'd2: cab_dout <= cab.ana3;   // 2P
                                        default: cab_dout <= cab.ana4;
                                    endcase
                                end
                                default: ;
                            endcase
                        end
                    end
                    default: ;   // Group 0 is the video control port
                endcase
            end
        end
    end

endmodule

//--- hdl/s16b_video_regs.sv
`timescale 1ns/100ps

module s16b_video_regs (
    input  logic                clk,
    input  logic                rst,
    input  s16b_pkg::cpu_bus_t  bus,
    input  s16b_pkg::chip_sel_t sel,
    output logic                flip,
    output logic                video_en,
    output logic [5:0]          tile_bank
);

    logic low_wr;     // Low byte write strobe
    logic ctrl_wr;
    logic tbank_wr;

    assign low_wr   = !bus.rnw && !bus.lds_n;
    assign ctrl_wr  = low_wr && sel.io && bus.addr[13:12] == 2'd0;
    assign tbank_wr = low_wr && sel.tbank;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            video_en <= 1'b1;   // Display on out of reset
        end else if (ctrl_wr) begin
            flip     <= bus.dout[6];
            video_en <= bus.dout[5];
        end
    end

    // A1 picks the upper or lower half of the bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= 6'd0;
        end else if (tbank_wr) begin
            if (bus.addr[1]) begin
                tile_bank[5:3] <= bus.dout[2:0];
            end else begin
                tile_bank[2:0] <= bus.dout[2:0];
            end
        end
    end

endmodule

//--- hdl/s16b_read_mux.sv
`timescale 1ns/100ps

module s16b_read_mux (
    input  logic                clk,
    input  logic                rst,
    input  s16b_pkg::chip_sel_t sel,
    input  logic [15:0]         rom_data,
    input  logic                rom_ok,
    input  logic [15:0]         ram_data,
    input  logic                ram_ok,
    input  logic [15:0]         text_dout,
    input  logic [15:0]         pal_dout,
    input  logic [15:0]         obj_dout,
    input  logic [7:0]          cab_dout,
    output logic [15:0]         cpu_din,
    output logic                bus_ready
);

    logic io_wait;     // Extra stage while cab_dout settles
    logic ready_nxt;

    always_comb begin
        ready_nxt = ((sel.ram || sel.vram) && ram_ok) ||
                    (sel.rom && rom_ok) ||
                    sel.text || sel.pal || sel.objram || sel.tbank ||
                    (sel.io && io_wait);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din   <= 16'hffff;
            bus_ready <= 1'b0;
            io_wait   <= 1'b0;
        end else begin
            io_wait   <= sel.io;
            bus_ready <= ready_nxt;
            if (sel.ram || sel.vram) begin
                cpu_din <= ram_data;
            end else if (sel.rom) begin
                cpu_din <= rom_data;
            end else if (sel.text) begin
                cpu_din <= text_dout;
            end else if (sel.pal) begin
                cpu_din <= pal_dout;
            end else if (sel.objram) begin
                cpu_din <= obj_dout;
            end else if (sel.io) begin
                cpu_din <= {8'hff, cab_dout};
            end
            // Unmapped cycles keep the last value
        end
    end

endmodule

//--- hdl/s16b_main_io.sv
`timescale 1ns/100ps

module s16b_main_io (
    input  logic                clk,
    input  logic                rst,

    input  s16b_pkg::cpu_bus_t  bus,
    input  logic [7:0]          game_id,
    input  s16b_pkg::cab_in_t   cab,
    input  s16b_pkg::dip_t      dip,

    // Read data from the memories and video blocks
    input  logic [15:0]         rom_data,
    input  logic                rom_ok,
    input  logic [15:0]         ram_data,
    input  logic                ram_ok,
    input  logic [15:0]         text_dout,
    input  logic [15:0]         pal_dout,
    input  logic [15:0]         obj_dout,

    output s16b_pkg::chip_sel_t sel,
    output logic [17:0]         rom_addr,
    output logic [15:0]         cpu_din,
    output logic                bus_ready,
    output logic                flip,
    output logic                video_en,
    output logic [5:0]          tile_bank,
    output logic                halt_n
);

    logic [7:0] cab_dout;

    assign halt_n = dip.dip_pause;   // Pause DIP holds the CPU

    s16b_mem_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .game_id  (game_id),
        .sel      (sel),
        .rom_addr (rom_addr)
    );

    s16b_cab_io u_cab (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .sel      (sel),
        .game_id  (game_id),
        .cab      (cab),
        .dip      (dip),
        .cab_dout (cab_dout)
    );

    s16b_video_regs u_video (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .sel       (sel),
        .flip      (flip),
        .video_en  (video_en),
        .tile_bank (tile_bank)
    );

    s16b_read_mux u_rdmux (
        .clk       (clk),
        .rst       (rst),
        .sel       (sel),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .text_dout (text_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din),
        .bus_ready (bus_ready)
    );

endmodule

//--- test/s16b_main_assertions.sv
`timescale 1ns/100ps

module s16b_main_assertions (
    input logic                clk,
    input logic                rst,
    input s16b_pkg::cpu_bus_t  bus,
    input s16b_pkg::chip_sel_t sel
);

    int unsigned err_cnt = 0;   // Failed assertions so far
    logic [7:0]  sel_bits;

    assign sel_bits = sel;

    // Regions never overlap
    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel_bits))
        else begin
            err_cnt++;
            $error("more than one chip select is high");
        end

    sel_in_rst: assert property (@(posedge clk) rst |-> sel_bits == 8'd0)
        else begin
            err_cnt++;
            $error("chip select high during reset");
        end

    // A select only rises for a cycle that AS has opened
    sel_after_as: assert property (@(posedge clk) disable iff (rst)
        (|(sel_bits & ~$past(sel_bits))) |-> !$past(bus.as_n))
        else begin
            err_cnt++;
            $error("chip select rose without AS low");
        end

endmodule

bind s16b_mem_decode s16b_main_assertions u_chk (.clk(clk), .rst(rst), .bus(bus), .sel(sel));

//--- test/s16b_main_tb.sv
`timescale 1ns/100ps

module s16b_main_tb;

    typedef struct packed {
        logic       flip;
        logic       video_en;
        logic [5:0] tile_bank;
    } vregs_t;

    typedef struct packed {
        logic [1:0]          kind;
        logic [7:0]          game;
        logic [23:0]         baddr;    // Byte address
        logic                rnw;
        logic [1:0]          strb_n;   // {uds_n, lds_n}
        logic [15:0]         dout;
        s16b_pkg::chip_sel_t exp_sel;
        logic [17:0]         exp_val;
        s16b_pkg::cab_in_t   cab;
        s16b_pkg::dip_t      dip;
    } entry_t;

    localparam logic [1:0] K_DATA = 2'd0, K_ADDR = 2'd1, K_VREG = 2'd2, K_NONE = 2'd3;
    localparam s16b_pkg::chip_sel_t SEL_ROM = 8'h80, SEL_RAM = 8'h40, SEL_VRAM = 8'h20;
    localparam s16b_pkg::chip_sel_t SEL_TEXT = 8'h10, SEL_OBJ = 8'h08, SEL_PAL = 8'h04;
    localparam s16b_pkg::chip_sel_t SEL_IO = 8'h02, SEL_TBANK = 8'h01;
    localparam logic [15:0] ROM_WORD = 16'ha55a, RAM_WORD = 16'h3c96, TEXT_WORD = 16'h7101;
    localparam logic [15:0] PAL_WORD = 16'h0e0f, OBJ_WORD = 16'h4b2d;
    localparam s16b_pkg::cab_in_t CAB_SET = {8'h01, 8'h80, 8'h10, 8'h2c, 8'h6a, 8'h14,
                                             8'h9a, 8'h5c, 4'b1010, 4'b0010, 1'b1, 3'b111};
    localparam s16b_pkg::dip_t DIP_SET = {8'h5a, 8'hc3, 1'b0, 1'b1};
    localparam int TIMEOUT = 40;   // Cycles

    logic clk, rst, rom_ok, ram_ok, bus_ready, flip, video_en, halt_n;
    logic [7:0]  game_id;
    logic [15:0] rom_data, ram_data, text_dout, pal_dout, obj_dout, cpu_din;
    logic [17:0] rom_addr;
    logic [5:0]  tile_bank;
    logic [31:0] rng_state;
    s16b_pkg::cpu_bus_t  bus;
    s16b_pkg::cab_in_t   cab;
    s16b_pkg::dip_t      dip;
    s16b_pkg::chip_sel_t sel;
    entry_t      table_q[$];
    logic [7:0]  shift_src [4] = '{8'h3f, 8'h6a, 8'h14, 8'hff};   // Halved sum, ana1, ana2, ones

    s16b_main_io UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Region 7, group, A9..A8 = 10, port on A2..A1
    function automatic logic [23:0] io_addr(input logic [1:0] grp, input logic [1:0] port);
        return {4'h7, 6'd0, grp, 2'b00, 2'b10, 5'd0, port, 1'b0};
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sel(input string name, input s16b_pkg::chip_sel_t got, exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, got));
    endtask

    task automatic check_word(input string name, input logic [15:0] got, exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, got));
    endtask

    task automatic check_addr(input string name, input logic [17:0] got, exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, got));
    endtask

    task automatic check_vregs(input string name, input vregs_t got, exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, exp, got));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error at %0t: %s expected %b, got %b",
                                    $time, name, exp, got));
    endtask

    task automatic check_count(input string name, input int got, exp);
        if (got != exp)
            stop_on_error($sformatf("** Error at %0t: %s expected %0d, got %0d",
                                    $time, name, exp, got));
    endtask

    task automatic add_entry(input logic [1:0] kind, input logic [7:0] game,
                             input logic [23:0] baddr, input logic rnw, input logic [1:0] strb_n,
                             input logic [15:0] dout, input s16b_pkg::chip_sel_t exp_sel,
                             input logic [17:0] exp_val);
        table_q.push_back({kind, game, baddr, rnw, strb_n, dout, exp_sel, exp_val,
                           CAB_SET, DIP_SET});
    endtask

    // Starts and ends on a falling edge
    task automatic run_cycle(input entry_t e);
        int n;
        int ok_delay;
        int exp_lat;
        rng_state = xorshift32(rng_state);
        ok_delay  = rng_state % 5;
        // Falling edges from the select to bus_ready
        if (e.exp_sel.rom || e.exp_sel.ram || e.exp_sel.vram)
            exp_lat = ok_delay + 1;
        else if (e.exp_sel.io)
            exp_lat = 2;
        else
            exp_lat = 1;
        game_id   = e.game;
        cab       = e.cab;
        dip       = e.dip;
        bus = '{addr: e.baddr[23:1], as_n: 1'b0, rnw: e.rnw, uds_n: e.strb_n[1],
                lds_n: e.strb_n[0], dout: e.dout};
        @(negedge clk);
        check_sel("sel", sel, e.exp_sel);
        if (e.kind == K_ADDR) check_addr("rom_addr", rom_addr, e.exp_val);
        n = 0;
        while (!bus_ready) begin
            if (n == ok_delay) begin
                rom_ok = 1'b1;   // Memory answers late
                ram_ok = 1'b1;
            end
            if (n == TIMEOUT) stop_on_error("bus_ready never rose during a bus cycle");
            @(negedge clk);
            n++;
        end
        check_count("bus_ready latency", n, exp_lat);
        if (e.kind == K_DATA) check_word("cpu_din", cpu_din, e.exp_val[15:0]);
        bus.as_n = 1'b1;
        rom_ok   = 1'b0;
        ram_ok   = 1'b0;
        n = 0;
        while (bus_ready || sel != '0) begin
            if (n == TIMEOUT) stop_on_error("bus cycle did not close after AS went high");
            @(negedge clk);
            n++;
        end
        if (e.kind == K_VREG) check_vregs("video regs", {flip, video_en, tile_bank}, e.exp_val[7:0]);
    endtask

    always @(negedge clk)
        if (UUT.u_decode.u_chk.err_cnt != 0) stop_on_error("A bound assertion failed");

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        rng_state = 32'd2;
        game_id = 8'h01;
        cab = CAB_SET;
        dip = DIP_SET;
        rom_data = ROM_WORD;
        ram_data = RAM_WORD;
        text_dout = TEXT_WORD;
        pal_dout = PAL_WORD;
        obj_dout = OBJ_WORD;
        bus = '{addr: '0, as_n: 1'b1, rnw: 1'b1, uds_n: 1'b1, lds_n: 1'b1, dout: '0};

        // One select per region, read data returned
        add_entry(K_DATA, 8'h01, 24'h012340, 1'b1, 2'b00, 16'h0, SEL_ROM, ROM_WORD);
        add_entry(K_DATA, 8'h01, 24'h301000, 1'b1, 2'b00, 16'h0, SEL_RAM, RAM_WORD);
        add_entry(K_DATA, 8'h01, 24'h500200, 1'b1, 2'b00, 16'h0, SEL_VRAM, RAM_WORD);
        add_entry(K_DATA, 8'h01, 24'h510200, 1'b1, 2'b00, 16'h0, SEL_TEXT, TEXT_WORD);
        add_entry(K_DATA, 8'h01, 24'h400100, 1'b1, 2'b00, 16'h0, SEL_OBJ, OBJ_WORD);
        add_entry(K_DATA, 8'h01, 24'h600100, 1'b1, 2'b00, 16'h0, SEL_PAL, PAL_WORD);
        // ROM address per board class
        add_entry(K_ADDR, 8'h20, 24'h2ebcde, 1'b1, 2'b00, 16'h0, SEL_ROM, 18'h35e6f);
        add_entry(K_ADDR, 8'h10, 24'h2ebcde, 1'b1, 2'b00, 16'h0, SEL_ROM, 18'h25e6f);
        add_entry(K_ADDR, 8'h1a, 24'h1ebcde, 1'b1, 2'b00, 16'h0, SEL_ROM, 18'h15e6f);
        add_entry(K_ADDR, 8'h11, 24'h1ebcde, 1'b1, 2'b00, 16'h0, SEL_ROM, 18'h0de6f);
        add_entry(K_ADDR, 8'h08, 24'h2ebcde, 1'b1, 2'b00, 16'h0, SEL_ROM, 18'h15e6f);
        add_entry(K_ADDR, 8'h01, 24'h1ebcde, 1'b1, 2'b00, 16'h0, SEL_ROM, 18'h35e6f);
        // Cabinet ports
        add_entry(K_DATA, 8'h20, io_addr(2'd1, 2'd0), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hffea);
        add_entry(K_DATA, 8'h20, io_addr(2'd1, 2'd1), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff40);
        add_entry(K_DATA, 8'h20, io_addr(2'd1, 2'd3), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff08);
        add_entry(K_DATA, 8'h11, io_addr(2'd1, 2'd0), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff2a);
        add_entry(K_DATA, 8'h11, io_addr(2'd1, 2'd1), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff04);
        add_entry(K_DATA, 8'h11, io_addr(2'd1, 2'd2), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff20);
        add_entry(K_DATA, 8'h02, io_addr(2'd1, 2'd0), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hffaa);
        add_entry(K_DATA, 8'h20, io_addr(2'd2, 2'd1), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff5a);
        add_entry(K_DATA, 8'h20, io_addr(2'd2, 2'd0), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hffc3);
        add_entry(K_DATA, 8'h13, io_addr(2'd3, 2'd0), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff04);
        add_entry(K_DATA, 8'h13, io_addr(2'd3, 2'd3), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff23);
        add_entry(K_DATA, 8'h12, io_addr(2'd3, 2'd2), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff9a);
        add_entry(K_DATA, 8'h19, io_addr(2'd3, 2'd1), 1'b1, 2'b10, 16'h0, SEL_IO, 18'hff14);
        // Heavy Champion shift port, load then eight reads MSB first
        for (int s = 0; s < 4; s++) begin
            add_entry(K_NONE, 8'h01, io_addr(2'd3, 2'(s)), 1'b0, 2'b10, 16'h0, SEL_IO, '0);
            for (int b = 7; b >= 0; b--)
                add_entry(K_DATA, 8'h01, io_addr(2'd3, 2'd0), 1'b1, 2'b10, 16'h0, SEL_IO,
                          {2'b00, 8'hff, 7'd0, shift_src[s][b]});
        end
        // Video registers as {flip, video_en, tile_bank}
        add_entry(K_VREG, 8'h01, io_addr(2'd0, 2'd0), 1'b0, 2'b10, 16'h0040, SEL_IO, 18'h80);
        add_entry(K_VREG, 8'h01, 24'h200002, 1'b0, 2'b10, 16'h0005, SEL_TBANK, 18'ha8);
        add_entry(K_VREG, 8'h01, 24'h200000, 1'b0, 2'b10, 16'h0003, SEL_TBANK, 18'hab);
        add_entry(K_VREG, 8'h01, io_addr(2'd0, 2'd0), 1'b0, 2'b01, 16'hffff, SEL_IO, 18'hab);
        add_entry(K_VREG, 8'h01, 24'h200000, 1'b0, 2'b01, 16'h0007, SEL_TBANK, 18'hab);
        add_entry(K_VREG, 8'h01, io_addr(2'd0, 2'd0), 1'b0, 2'b10, 16'h0020, SEL_IO, 18'h6b);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_sel("sel", sel, '0);
        check_bit("bus_ready", bus_ready, 1'b0);
        check_word("cpu_din", cpu_din, 16'hffff);
        check_vregs("video regs", {flip, video_en, tile_bank}, 8'h40);
        check_bit("halt_n", halt_n, 1'b1);

        dip.dip_pause = 1'b0;   // Pause switch on
        @(negedge clk);
        check_bit("halt_n", halt_n, 1'b0);

        foreach (table_q[i]) run_cycle(table_q[i]);

        if (UUT.u_decode.u_chk.err_cnt != 0) begin
            stop_on_error("A bound assertion failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

//--- filelist.f
hdl/s16b_pkg.sv
hdl/s16b_mem_decode.sv
hdl/s16b_cab_io.sv
hdl/s16b_video_regs.sv
hdl/s16b_read_mux.sv
hdl/s16b_main_io.sv
test/s16b_main_assertions.sv
test/s16b_main_tb.sv
